// File: hw/muldiv_settings.svh
// width and iteration count macros for the multiply/divide unit

`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// ------------------------------
// datapath sizing
// ------------------------------

// operand and result width
`define MD_XLEN 32

// restoring divider iterations, one quotient bit per step
`define MD_DIV_STEPS `MD_XLEN

`endif

// File: hw/muldiv_pkg.sv
// opcode and state enums, request and control structs

`default_nettype none

`include "muldiv_settings.svh"

package muldiv_pkg;

    // M-extension funct3 encoding
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } md_op_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        MUL_EXEC  = 3'd1,
        DIV_CHECK = 3'd2,
        DIV_EXEC  = 3'd3,
        RET       = 3'd4
    } md_state_e;

    typedef struct packed {
        md_op_e                op;    // funct3
        logic [`MD_XLEN-1:0]   src1;  // rs1 value
        logic [`MD_XLEN-1:0]   src2;  // rs2 value
    } md_req_t;

    typedef struct packed {
        logic load;   // capture request
        logic step;   // multiply or one divide iteration
        logic fixup;  // magnitude / zero-divisor handling
        logic ret;    // drive result
    } md_ctl_t;

endpackage

`default_nettype wire

// File: hw/muldiv_ctrl.sv
// control FSM for the multiply/divide unit
// step counter, busy/done and datapath strobes

`default_nettype none

`include "muldiv_settings.svh"

module muldiv_ctrl (
    input  logic                 clk_i,
    input  logic                 rst,
    input  logic                 hold_i,
    input  logic                 valid_i,
    input  muldiv_pkg::md_req_t  req_i,
    input  logic                 divisor_zero_i,
    output muldiv_pkg::md_ctl_t  ctl_o,
    output logic                 busy_o,
    output logic                 done_o
);
    import muldiv_pkg::*;

    localparam logic [4:0] step_last = 5'(`MD_DIV_STEPS - 1);

    md_state_e  state_q;
    md_state_e  state_d;
    logic [4:0] cnt_q;  // remaining divide steps
    logic [4:0] cnt_d;
    logic       is_div;

    assign is_div = req_i.op[2];  // funct3[2] marks the divide group

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        unique case (state_q)
            IDLE: begin
                if (valid_i) begin
                    state_d = is_div ? DIV_CHECK : MUL_EXEC;
                end
            end
            MUL_EXEC: begin
                state_d = RET;  // single-cycle product
            end
            DIV_CHECK: begin
                if (divisor_zero_i) begin
                    state_d = RET;  // short-circuit, results set by fixup
                end else begin
                    state_d = DIV_EXEC;
                    cnt_d   = step_last;
                end
            end
            DIV_EXEC: begin
                cnt_d = cnt_q - 5'd1;
                if (cnt_q == 5'd0) begin
                    state_d = RET;
                end
            end
            RET: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (!hold_i) begin  // freeze everything on hold
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // ------------------------------
    // strobes and status
    // ------------------------------
    always_comb begin
        ctl_o.load  = (state_q == IDLE) && valid_i;
        ctl_o.step  = (state_q == MUL_EXEC) || (state_q == DIV_EXEC);
        ctl_o.fixup = (state_q == DIV_CHECK);
        ctl_o.ret   = (state_q == RET);
    end

    assign busy_o = (state_q != IDLE);  // includes the RET cycle
    assign done_o = (state_q == RET);

endmodule

`default_nettype wire

// File: hw/mul_datapath.sv
// multiplier datapath with 33x33 signed product register

`default_nettype none

`include "muldiv_settings.svh"

module mul_datapath (
    input  logic                 clk_i,
    input  logic                 hold_i,
    input  muldiv_pkg::md_req_t  req_i,
    input  muldiv_pkg::md_ctl_t  ctl_i,
    output logic [`MD_XLEN-1:0]  rslt_o
);
    import muldiv_pkg::*;

    logic signed [`MD_XLEN:0]     src1_q;  // 33 bit
    logic signed [`MD_XLEN:0]     src2_q;
    logic signed [2*`MD_XLEN+1:0] prod_q;  // 66 bit
    logic                         hi_q;    // return upper word
    logic                         own_q;   // request is a multiply
    logic                         src1_signed;
    logic                         src2_signed;

    assign src1_signed = (req_i.op == MULH) || (req_i.op == MULHSU);
    assign src2_signed = (req_i.op == MULH);

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            if (ctl_i.load) begin
                src1_q <= {src1_signed && req_i.src1[`MD_XLEN-1], req_i.src1};
                src2_q <= {src2_signed && req_i.src2[`MD_XLEN-1], req_i.src2};
                hi_q   <= (req_i.op != MUL);
                own_q  <= !req_i.op[2];
            end
            if (ctl_i.step && own_q) begin
                prod_q <= src1_q * src2_q;  // operands sign-extend to full width
            end
        end
    end

    // zero unless returning our own result, so the top can OR
    assign rslt_o = !(ctl_i.ret && own_q) ? '0 :
                    hi_q ? prod_q[2*`MD_XLEN-1:`MD_XLEN] : prod_q[`MD_XLEN-1:0];

endmodule

`default_nettype wire

// File: hw/div_datapath.sv
// restoring shift-subtract divider datapath
// sign handling, zero-divisor results and quotient/remainder select

`default_nettype none

`include "muldiv_settings.svh"

module div_datapath (
    input  logic                 clk_i,
    input  logic                 hold_i,
    input  muldiv_pkg::md_req_t  req_i,
    input  muldiv_pkg::md_ctl_t  ctl_i,
    output logic                 divisor_zero_o,
    output logic [`MD_XLEN-1:0]  rslt_o
);
    import muldiv_pkg::*;

    logic [`MD_XLEN-1:0] divisor_q;
    logic [`MD_XLEN-1:0] rem_q;       // dividend until fixup, then partial remainder
    logic [`MD_XLEN-1:0] quo_q;
    logic                divisor_neg_q;
    logic                quo_neg_q;
    logic                rem_neg_q;   // remainder follows the dividend sign
    logic                is_rem_q;
    logic                own_q;
    logic                op_signed;

    logic [`MD_XLEN-1:0] dividend_mag;
    logic [`MD_XLEN-1:0] divisor_mag;
    logic [`MD_XLEN:0]   shifted;     // partial remainder with next dividend bit
    logic [`MD_XLEN+1:0] diff;
    logic                q_bit;

    assign op_signed = (req_i.op == DIV) || (req_i.op == REM);

    assign dividend_mag = rem_neg_q ? -rem_q : rem_q;
    assign divisor_mag  = divisor_neg_q ? -divisor_q : divisor_q;

    // ------------------------------
    // one restoring iteration
    // ------------------------------
    assign shifted = {rem_q, quo_q[`MD_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
    assign q_bit   = !diff[`MD_XLEN+1];  // no borrow means subtract fits

    assign divisor_zero_o = (divisor_q == '0);  // raw divisor, sampled in DIV_CHECK

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            if (ctl_i.load) begin
                divisor_q     <= req_i.src2;
                rem_q         <= req_i.src1;
                quo_q         <= '0;
                divisor_neg_q <= op_signed && req_i.src2[`MD_XLEN-1];
                rem_neg_q     <= op_signed && req_i.src1[`MD_XLEN-1];
                quo_neg_q     <= op_signed && (req_i.src1[`MD_XLEN-1] ^ req_i.src2[`MD_XLEN-1]);
                is_rem_q      <= req_i.op[1];  // REM and REMU
                own_q         <= req_i.op[2];
            end
            if (ctl_i.fixup) begin
                if (divisor_zero_o) begin
                    quo_q     <= '1;  // x/0 gives all ones, remainder keeps x
                    quo_neg_q <= 1'b0;
                    rem_neg_q <= 1'b0;
                end else begin
                    divisor_q <= divisor_mag;
                    rem_q     <= '0;
                    quo_q     <= dividend_mag;  // shifted out msb first
                end
            end
            if (ctl_i.step && own_q) begin
                rem_q <= q_bit ? diff[`MD_XLEN-1:0] : shifted[`MD_XLEN-1:0];
                quo_q <= {quo_q[`MD_XLEN-2:0], q_bit};
            end
        end
    end

    // sign correction on the way out
    always_comb begin
        rslt_o = '0;
        if (ctl_i.ret && own_q) begin
            if (is_rem_q) begin
                rslt_o = rem_neg_q ? -rem_q : rem_q;
            end else begin
                rslt_o = quo_neg_q ? -quo_q : quo_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/muldiv_unit.sv
// multiply/divide unit top level
// controller, multiplier and divider datapaths, result merge

`default_nettype none

`include "muldiv_settings.svh"

module muldiv_unit (
    input  logic                 clk_i,
    input  logic                 rst,
    input  logic                 hold_i,
    input  logic                 valid_i,
    input  muldiv_pkg::md_req_t  req_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [`MD_XLEN-1:0]  rslt_o
);
    import muldiv_pkg::*;

    md_ctl_t             ctl;
    logic                divisor_zero;
    logic [`MD_XLEN-1:0] mul_rslt;
    logic [`MD_XLEN-1:0] div_rslt;

    muldiv_ctrl ctrl0 (
        .clk_i          (clk_i),
        .rst            (rst),
        .hold_i         (hold_i),
        .valid_i        (valid_i),
        .req_i          (req_i),
        .divisor_zero_i (divisor_zero),
        .ctl_o          (ctl),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    mul_datapath mul0 (
        .clk_i  (clk_i),
        .hold_i (hold_i),
        .req_i  (req_i),
        .ctl_i  (ctl),
        .rslt_o (mul_rslt)
    );

    div_datapath div0 (
        .clk_i          (clk_i),
        .hold_i         (hold_i),
        .req_i          (req_i),
        .ctl_i          (ctl),
        .divisor_zero_o (divisor_zero),
        .rslt_o         (div_rslt)
    );

    assign rslt_o = mul_rslt | div_rslt;  // idle side drives zero

endmodule

`default_nettype wire

// File: verification/muldiv_chk.sv
// reference model and concurrent assertions for the multiply/divide unit

`default_nettype none

`include "muldiv_settings.svh"

module muldiv_chk (
    input logic                 clk_i,
    input logic                 rst,
    input logic                 hold_i,
    input logic                 valid_i,
    input muldiv_pkg::md_req_t  req_i,
    input logic                 busy_o,
    input logic                 done_o,
    input logic [`MD_XLEN-1:0]  rslt_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import muldiv_pkg::*;

    int                  fail_cnt = 0;
    logic                pend_q;    // operation in flight
    logic [5:0]          wait_q;    // unheld edges left before done_o
    logic [`MD_XLEN-1:0] exp_q;
    logic [`MD_XLEN-1:0] exp_rslt;
    logic                exp_done;
    logic                accept;

    // RISC-V M results, products formed at full 64-bit width
    function automatic logic [`MD_XLEN-1:0] ref_result(md_req_t r);
        logic [2*`MD_XLEN-1:0]      ea;
        logic [2*`MD_XLEN-1:0]      eb;
        logic [2*`MD_XLEN-1:0]      prod;
        logic signed [`MD_XLEN-1:0] sa;
        logic signed [`MD_XLEN-1:0] sb;
        logic [`MD_XLEN-1:0]        quo;
        logic [`MD_XLEN-1:0]        rem;
        logic                       ovf;  // most negative over -1
        sa   = r.src1;
        sb   = r.src2;
        ovf  = (r.op == DIV || r.op == REM) && (r.src2 == '1) &&
               (r.src1 == {1'b1, {(`MD_XLEN-1){1'b0}}});
        ea   = (r.op == MULH || r.op == MULHSU) ? {{`MD_XLEN{r.src1[`MD_XLEN-1]}}, r.src1}
                                                : {{`MD_XLEN{1'b0}}, r.src1};
        eb   = (r.op == MULH) ? {{`MD_XLEN{r.src2[`MD_XLEN-1]}}, r.src2}
                              : {{`MD_XLEN{1'b0}}, r.src2};
        prod = ea * eb;
        if (r.src2 == '0) begin
            quo = '1;  // x/0
            rem = r.src1;
        end else if (ovf) begin
            quo = r.src1;
            rem = '0;
        end else if (r.op == DIV || r.op == REM) begin
            quo = sa / sb;  // truncating, remainder follows dividend
            rem = sa % sb;
        end else begin
            quo = r.src1 / r.src2;
            rem = r.src1 % r.src2;
        end
        case (r.op)
            MUL:                 return prod[`MD_XLEN-1:0];
            MULH, MULHSU, MULHU: return prod[2*`MD_XLEN-1:`MD_XLEN];
            DIV, DIVU:           return quo;
            default:             return rem;
        endcase
    endfunction

    // ------------------------------
    // request tracking
    // ------------------------------
    assign accept   = !pend_q && valid_i && !hold_i;
    assign exp_done = pend_q && (wait_q == '0);
    assign exp_rslt = exp_done ? exp_q : '0;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            pend_q <= 1'b0;
            wait_q <= '0;
        end else if (accept) begin
            pend_q <= 1'b1;
            wait_q <= (!req_i.op[2] || req_i.src2 == '0) ? 6'd1 : 6'(`MD_DIV_STEPS + 1);
            exp_q  <= ref_result(req_i);
        end else if (pend_q && !hold_i) begin
            if (wait_q == '0) begin
                pend_q <= 1'b0;  // done cycle consumed
            end
            wait_q <= wait_q - 6'd1;
        end
    end

    // ------------------------------
    // assertions
    // ------------------------------
    result_ok: assert property (@(posedge clk_i) disable iff (rst) rslt_o == exp_rslt)
        else begin
            fail_cnt++;
            $error("Mismatch rslt_o expected %h actual %h",
                   $sampled(exp_rslt), $sampled(rslt_o));
        end

    done_ok: assert property (@(posedge clk_i) disable iff (rst) done_o == exp_done)
        else begin
            fail_cnt++;
            $error("done_o did not follow the expected latency");
        end

    busy_ok: assert property (@(posedge clk_i) disable iff (rst) busy_o == pend_q)
        else begin
            fail_cnt++;
            $error("busy_o does not match the operation in flight");
        end

    hold_ok: assert property (@(posedge clk_i) disable iff (rst)
                              hold_i |=> $stable(busy_o) && $stable(done_o) && $stable(rslt_o))
        else begin
            fail_cnt++;
            $error("outputs changed while hold_i was high");
        end

endmodule

`default_nettype wire

// File: verification/muldiv_tb.sv
// testbench for the multiply/divide unit
// clock, reset, directed and random requests, timeout and summary

`default_nettype none

`include "muldiv_settings.svh"

module muldiv_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import muldiv_pkg::*;

    localparam int max_cycles = 6000;  // ~120 ops at up to 40 cycles, plus hold cycles

    logic                clk_i;
    logic                rst;
    logic                hold_i;
    logic                valid_i;
    md_req_t             req_i;
    logic                busy_o;
    logic                done_o;
    logic [`MD_XLEN-1:0] rslt_o;

    int                  cycles = 0;
    int                  tests  = 0;
    logic [`MD_XLEN-1:0] corners [5] = '{32'h0, 32'h1, 32'hffff_ffff,
                                         32'h8000_0000, 32'h7fff_ffff};

    muldiv_unit dut0 (.*);

    bind muldiv_unit muldiv_chk chk0 (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    // ------------------------------
    // watchdog
    // ------------------------------
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= max_cycles);
        $display("run timed out after %0d cycles waiting for done_o", max_cycles);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [`MD_XLEN-1:0] pick_operand();
        if ($urandom_range(3) == 0) begin
            return corners[$urandom_range(4)];  // corner value one time in four
        end
        return $urandom;
    endfunction

    // one request from idle through its done_o cycle
    task automatic run_op(input md_op_e op, input logic [`MD_XLEN-1:0] a,
                          input logic [`MD_XLEN-1:0] b, input bit use_hold, input bit poke);
        int                  errs_before;
        logic [`MD_XLEN-1:0] got;
        errs_before = dut0.chk0.fail_cnt;
        hold_i      = 1'b0;
        valid_i     = 1'b0;
        while (busy_o) begin
            @(posedge clk_i);
            #10;
        end
        req_i   = '{op: op, src1: a, src2: b};
        valid_i = 1'b1;
        hold_i  = use_hold;  // held request must not be taken
        if (use_hold) begin
            @(posedge clk_i);
            #10;
            hold_i = 1'b0;
        end
        @(posedge clk_i);  // accepting edge
        #10;
        do begin
            valid_i = poke && ($urandom_range(1) == 1);  // ignored while busy
            req_i   = '{op: md_op_e'($urandom_range(7)), src1: $urandom, src2: $urandom};
            hold_i  = use_hold && ($urandom_range(2) == 0);
            @(posedge clk_i);
            #10;
        end while (!done_o);
        got     = rslt_o;
        valid_i = 1'b0;
        hold_i  = use_hold && ($urandom_range(1) == 1);  // sometimes freeze the done cycle
        @(posedge clk_i);  // result checked at this edge
        #10;
        tests++;
        $display("test %0d %s src1=%h src2=%h rslt_o=%h %s", tests, op.name(), a, b, got,
                 (dut0.chk0.fail_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        void'($urandom(36181));
        rst     = 1'b1;
        hold_i  = 1'b0;
        valid_i = 1'b0;
        req_i   = '0;
        repeat (4) @(posedge clk_i);
        #10;
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk_i);
            #10;
        end
        tests++;
        $display("test %0d reset busy_o=%b done_o=%b %s", tests, busy_o, done_o,
                 (dut0.chk0.fail_cnt == 0) ? "ok" : "FAILED");

        // corner pairs, covers MIN / -1 and divide by zero
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < 5; i++) begin
                run_op(md_op_e'(op), corners[i], corners[(i + 4) % 5], 1'b0, 1'b0);
            end
        end

        for (int n = 0; n < 80; n++) begin
            run_op(md_op_e'($urandom_range(7)), pick_operand(), pick_operand(),
                   n % 2 == 1, n % 3 == 0);
        end

        repeat (2) @(posedge clk_i);
        $display("%0d tests run, %0d assertion failures", tests, dut0.chk0.fail_cnt);
        if (dut0.chk0.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: muldiv_unit.f
+incdir+hw
hw/muldiv_pkg.sv
hw/muldiv_ctrl.sv
hw/mul_datapath.sv
hw/div_datapath.sv
hw/muldiv_unit.sv
verification/muldiv_chk.sv
verification/muldiv_tb.sv
